// File: verilog/obj_geom_pkg.sv
`default_nettype none

package obj_geom_pkg;

    // frame table written by the CPU
    localparam int frame_aw    = 10;
    localparam int entry_words = 4;    // x, y, code, attr at 4k..4k+3
    localparam int entry_cnt   = 256;

    // one line of the double line buffer
    localparam int line_slots  = 128;  // records per line
    localparam int slot_words  = 4;    // three in use
    localparam int line_aw     = 10;   // bank bit on top
    localparam int slot_aw     = 7;

endpackage

`default_nettype wire

// File: verilog/obj_attr_pkg.sv
`default_nettype none

package obj_attr_pkg;

    // attribute word fields
    localparam int attr_tile_m_lsb = 12;  // rows minus one, 4 bits
    localparam int attr_tile_n_lsb = 8;   // columns minus one, 4 bits
    localparam int attr_vflip_bit  = 6;
    localparam int attr_hflip_bit  = 5;
    localparam int attr_pal_w      = 5;

    localparam int tile_px = 16;  // pixels per tile, both directions

    // words inside one line record
    localparam logic [1:0] rec_code  = 2'd0;
    localparam logic [1:0] rec_vattr = 2'd1;  // row offset over attr bits 7:0
    localparam logic [1:0] rec_x     = 2'd2;

    // marks a record with no sprite
    localparam logic [15:0] fill_word = 16'hffff;

endpackage

`default_nettype wire

// File: verilog/obj_line_if.sv
`timescale 1ns/1ns
`default_nettype none

interface obj_line_if
    import obj_geom_pkg::*;
();

    logic                 ready;    // line complete, one cycle
    logic                 bank;     // finished bank
    logic [slot_aw:0]     count;    // real records, 0 to 128
    logic [line_aw-1:0]   rd_addr;  // bank, record, word
    logic [15:0]          rd_data;  // one clock after rd_addr

    modport builder (
        output ready, bank, count, rd_data,
        input  rd_addr
    );

    modport scanner (
        input  ready, bank, count, rd_data,
        output rd_addr
    );

endinterface

`default_nettype wire

// File: verilog/obj_frame_table.sv
`timescale 1ns/1ns
`default_nettype none

module obj_frame_table
    import obj_geom_pkg::*;
(
    input  wire                  clk,

    // CPU write port
    input  wire                  cpu_we,
    input  wire  [frame_aw-1:0]  cpu_addr,
    input  wire  [15:0]          cpu_data,

    // builder read port
    input  wire  [frame_aw-1:0]  frame_addr,
    output logic [15:0]          frame_data
);

    logic [15:0] mem [0:entry_cnt*entry_words-1];

    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_data;
        end
    end

    // registered read, data one clock after the address
    always_ff @(posedge clk) begin
        frame_data <= mem[frame_addr];
    end

endmodule

`default_nettype wire

// File: verilog/obj_line_table.sv
`timescale 1ns/1ns
`default_nettype none

module obj_line_table
    import obj_geom_pkg::*;
    import obj_attr_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst,

    input  wire                  start,
    input  wire  [7:0]           vrender,

    output logic [frame_aw-1:0]  frame_addr,
    input  wire  [15:0]          frame_data,

    obj_line_if.builder          line
);

    localparam logic [2:0] st_idle  = 3'd0;
    localparam logic [2:0] st_fetch = 3'd1;
    localparam logic [2:0] st_check = 3'd2;
    localparam logic [2:0] st_rec   = 3'd3;
    localparam logic [2:0] st_next  = 3'd4;
    localparam logic [2:0] st_fill  = 3'd5;

    logic [2:0]         st;
    logic [2:0]         fc;         // fetch step
    logic [1:0]         widx;       // word inside the record
    logic [3:0]         n;          // tile column
    logic [7:0]         ent;        // current entry
    logic [slot_aw:0]   line_cnt;
    logic [slot_aw:0]   real_cnt;
    logic               have_last;
    logic [7:0]         vr_q;

    logic [15:0]        obj_x, obj_y, obj_code, obj_attr;
    logic [15:0]        last_x, last_y, last_code, last_attr;

    logic [15:0]        line_buf [0:2*line_slots*slot_words-1];

    logic [3:0]             tile_m, tile_n;
    logic                   vflip, hflip;
    logic [attr_pal_w-1:0]  pal;
    logic [7:0]             dy;
    logic [8:0]             zone_lim;
    logic                   in_zone, dup;
    logic [3:0]             vsub;
    logic [15:0]            code_mn, vattr_w, x_w;
    logic                   wr_en;
    logic [line_aw-1:0]     wr_addr;
    logic [15:0]            wr_data;

    assign tile_m = obj_attr[attr_tile_m_lsb +: 4];
    assign tile_n = obj_attr[attr_tile_n_lsb +: 4];
    assign vflip  = obj_attr[attr_vflip_bit];
    assign hflip  = obj_attr[attr_hflip_bit];
    assign pal    = obj_attr[attr_pal_w-1:0];

    // row match, wraps past line 255
    assign dy       = vr_q - obj_y[7:0];
    assign zone_lim = ({5'd0, tile_m} + 9'd1) * 9'(tile_px);
    assign in_zone  = {1'b0, dy} < zone_lim;
    assign dup      = have_last && (obj_x == last_x) && (obj_y == last_y) &&
                      (obj_code == last_code) && (obj_attr == last_attr);
    assign vsub     = dy[3:0] ^ {4{vflip}};

    always_comb begin
        case ({tile_m != 4'd0, tile_n != 4'd0})
            2'b00:   code_mn = obj_code;
            2'b01:   code_mn = {obj_code[15:4], n ^ {4{hflip}}};
            2'b10:   code_mn = {obj_code[15:8], dy[7:4], obj_code[3:0] ^ {4{vflip}}};
            default: code_mn = {obj_code[15:8], dy[7:4], n ^ {4{hflip}}};
        endcase
    end

    assign vattr_w = {4'd0, vsub, obj_attr[7:attr_pal_w], pal};  // flags over palette
    assign x_w     = obj_x + 16'(n) * 16'(tile_px);

    // buffer write side
    always_comb begin
        wr_en   = 1'b0;
        wr_data = fill_word;
        if (st == st_rec) begin
            wr_en = 1'b1;
            case (widx)
                rec_code:  wr_data = code_mn;
                rec_vattr: wr_data = vattr_w;
                default:   wr_data = x_w;
            endcase
        end else if (st == st_fill) begin
            wr_en = 1'b1;
        end
    end

    assign wr_addr = {vr_q[0], line_cnt[slot_aw-1:0], widx};

    always_ff @(posedge clk) begin
        if (wr_en) begin
            line_buf[wr_addr] <= wr_data;
        end
        line.rd_data <= line_buf[line.rd_addr];  // scanner side
    end

    // entry words arrive top address first
    always_ff @(posedge clk) begin
        if (st == st_fetch) begin
            case (fc)
                3'd1: begin
                    last_attr <= obj_attr;
                    obj_attr  <= frame_data;
                end
                3'd2: begin
                    last_code <= obj_code;
                    obj_code  <= frame_data;
                end
                3'd3: begin
                    last_y <= obj_y;
                    obj_y  <= frame_data;
                end
                3'd4: begin
                    last_x <= obj_x;
                    obj_x  <= frame_data;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st         <= st_idle;
            fc         <= 3'd0;
            widx       <= rec_code;
            n          <= 4'd0;
            ent        <= 8'd0;
            line_cnt   <= '0;
            real_cnt   <= '0;
            have_last  <= 1'b0;
            vr_q       <= 8'd0;
            frame_addr <= '0;
            line.ready <= 1'b0;
            line.bank  <= 1'b0;
            line.count <= '0;
        end else begin
            line.ready <= 1'b0;
            case (st)
                st_idle: begin
                    if (start) begin
                        vr_q       <= vrender;
                        ent        <= 8'(entry_cnt - 1);
                        frame_addr <= frame_aw'(entry_cnt * entry_words - 1);
                        fc         <= 3'd0;
                        line_cnt   <= '0;
                        have_last  <= 1'b0;
                        st         <= st_fetch;
                    end
                end
                st_fetch: begin
                    if (fc != 3'd4) begin
                        frame_addr <= frame_addr - 1'b1;  // ends on next entry's attr
                        fc         <= fc + 3'd1;
                    end else begin
                        st <= st_check;
                    end
                end
                st_check: begin
                    have_last <= 1'b1;
                    if (!in_zone || dup) begin
                        st <= st_next;
                    end else begin
                        n    <= 4'd0;
                        widx <= rec_code;
                        st   <= st_rec;
                    end
                end
                st_rec: begin
                    if (widx == rec_x) begin
                        widx     <= rec_code;
                        line_cnt <= line_cnt + 1'b1;
                        if (line_cnt == (slot_aw + 1)'(line_slots - 1)) begin
                            line.ready <= 1'b1;  // line full
                            line.bank  <= vr_q[0];
                            line.count <= (slot_aw + 1)'(line_slots);
                            st         <= st_idle;
                        end else if (n == tile_n) begin
                            st <= st_next;
                        end else begin
                            n <= n + 4'd1;
                        end
                    end else begin
                        widx <= widx + 2'd1;
                    end
                end
                st_next: begin
                    if (ent == 8'd0) begin
                        real_cnt <= line_cnt;
                        widx     <= rec_code;
                        st       <= st_fill;
                    end else begin
                        ent <= ent - 8'd1;
                        fc  <= 3'd0;
                        st  <= st_fetch;
                    end
                end
                st_fill: begin
                    if (widx == rec_x) begin
                        widx <= rec_code;
                        if (line_cnt == (slot_aw + 1)'(line_slots - 1)) begin
                            line.ready <= 1'b1;
                            line.bank  <= vr_q[0];
                            line.count <= real_cnt;
                            st         <= st_idle;
                        end else begin
                            line_cnt <= line_cnt + 1'b1;
                        end
                    end else begin
                        widx <= widx + 2'd1;
                    end
                end
                default: st <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/obj_line_scan.sv
`timescale 1ns/1ns
`default_nettype none

module obj_line_scan
    import obj_geom_pkg::*;
    import obj_attr_pkg::*;
(
    input  wire          clk,
    input  wire          rst,

    obj_line_if.scanner  line,

    output logic         spr_valid,
    output logic [15:0]  spr_code,
    output logic [15:0]  spr_x,
    output logic [ 3:0]  spr_vsub,
    output logic [ 7:0]  spr_attr,
    output logic         line_end
);

    logic                act;       // still issuing reads
    logic                bank_q;
    logic [slot_aw:0]    cnt_q;
    logic [slot_aw-1:0]  slot;
    logic [1:0]          w;
    logic                is_last;
    logic                p1_v, p2_v;
    logic [1:0]          p1_w, p2_w;
    logic                p1_last, p2_last;
    logic                end_q;

    assign is_last = {1'b0, slot} == cnt_q - 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            act          <= 1'b0;
            bank_q       <= 1'b0;
            cnt_q        <= '0;
            slot         <= '0;
            w            <= rec_code;
            p1_v         <= 1'b0;
            p2_v         <= 1'b0;
            p1_w         <= rec_code;
            p2_w         <= rec_code;
            p1_last      <= 1'b0;
            p2_last      <= 1'b0;
            end_q        <= 1'b0;
            spr_valid    <= 1'b0;
            line_end     <= 1'b0;
            line.rd_addr <= '0;
        end else begin
            spr_valid <= 1'b0;
            end_q     <= 1'b0;
            line_end  <= end_q;
            if (line.ready) begin
                // new line, drop anything in flight
                bank_q   <= line.bank;
                cnt_q    <= line.count;
                slot     <= '0;
                w        <= rec_code;
                act      <= line.count != '0;
                p1_v     <= 1'b0;
                p2_v     <= 1'b0;
                line_end <= line.count == '0;
            end else begin
                p1_v    <= act;
                p1_w    <= w;
                p1_last <= is_last;
                p2_v    <= p1_v;     // RAM read in progress
                p2_w    <= p1_w;
                p2_last <= p1_last;
                if (p2_v && p2_w == rec_x) begin
                    spr_valid <= 1'b1;
                    end_q     <= p2_last;
                end
                if (act) begin
                    line.rd_addr <= {bank_q, slot, w};
                    if (w == rec_x) begin
                        w <= rec_code;
                        if (is_last) begin
                            act <= 1'b0;
                        end else begin
                            slot <= slot + 1'b1;
                        end
                    end else begin
                        w <= w + 2'd1;
                    end
                end
            end
        end
    end

    // record words land here as they come back
    always_ff @(posedge clk) begin
        if (p2_v) begin
            case (p2_w)
                rec_code: spr_code <= line.rd_data;
                rec_vattr: begin
                    spr_vsub <= line.rd_data[11:8];
                    spr_attr <= line.rd_data[7:0];
                end
                default: spr_x <= line.rd_data;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/obj_line_top.sv
`timescale 1ns/1ns
`default_nettype none

module obj_line_top
    import obj_geom_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst,

    // CPU side of the frame table
    input  wire                  cpu_we,
    input  wire  [frame_aw-1:0]  cpu_addr,
    input  wire  [15:0]          cpu_data,

    input  wire                  start,
    input  wire  [7:0]           vrender,   // row being built, bit 0 picks the bank

    output wire                  spr_valid,
    output wire  [15:0]          spr_code,
    output wire  [15:0]          spr_x,
    output wire  [ 3:0]          spr_vsub,
    output wire  [ 7:0]          spr_attr,
    output wire                  line_end
);

    logic [frame_aw-1:0]  frame_addr;
    logic [15:0]          frame_data;

    obj_line_if line_bus ();

    obj_frame_table u_frame (
        .clk        (clk),
        .cpu_we     (cpu_we),
        .cpu_addr   (cpu_addr),
        .cpu_data   (cpu_data),
        .frame_addr (frame_addr),
        .frame_data (frame_data)
    );

    obj_line_table u_table (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .vrender    (vrender),
        .frame_addr (frame_addr),
        .frame_data (frame_data),
        .line       (line_bus.builder)
    );

    obj_line_scan u_scan (
        .clk        (clk),
        .rst        (rst),
        .line       (line_bus.scanner),
        .spr_valid  (spr_valid),
        .spr_code   (spr_code),
        .spr_x      (spr_x),
        .spr_vsub   (spr_vsub),
        .spr_attr   (spr_attr),
        .line_end   (line_end)
    );

endmodule

`default_nettype wire

// File: dv/obj_tb_clkgen.sv
`timescale 1ns/1ns
`default_nettype none

module obj_tb_clkgen (
    output logic clk,
    output logic rst
);

    localparam int half_period  = 10;  // 20 ns clock
    localparam int reset_cycles = 10;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: dv/obj_line_checker.sv
`timescale 1ns/1ns
`default_nettype none

module obj_line_checker (
    input  wire         clk,
    input  wire         rst,
    input  wire         spr_valid,
    input  wire  [15:0] spr_code,
    input  wire  [15:0] spr_x,
    input  wire  [ 3:0] spr_vsub,
    input  wire  [ 7:0] spr_attr,
    input  wire         line_end
);

    logic [43:0] exp_q [$];  // {code, x, vsub, attr}
    logic [43:0] exp_rec;
    string       test_name   = "none";
    bit          line_open   = 1'b0;
    int          got_in_line = 0;
    int          since_valid = 0;  // negedges since the last record
    int          value_errs  = 0;
    int          proto_errs  = 0;
    int          records     = 0;
    int          lines_done  = 0;

    task automatic begin_line(input string name);
        test_name   = name;
        line_open   = 1'b1;
        got_in_line = 0;
        exp_q.delete();
    endtask

    task automatic push_rec(input logic [15:0] code, input logic [15:0] x,
                            input logic [3:0] vsub, input logic [7:0] attr);
        exp_q.push_back({code, x, vsub, attr});
    endtask

    task automatic compare(input string field, input logic [15:0] exp_v,
                           input logic [15:0] act_v);
        if (exp_v !== act_v) begin
            value_errs++;
            $display("FAIL %s: %s expected %h actual %h", test_name, field, exp_v, act_v);
        end
    endtask

    // outputs settle after the rising edge, sample in the middle of the cycle
    always @(negedge clk) begin
        if (!rst) begin
            since_valid++;
            if (spr_valid === 1'b1) begin
                if (!line_open) begin
                    proto_errs++;
                    $display("spr_valid pulsed with no line in progress at %0t", $time);
                end else if (exp_q.size() == 0) begin
                    proto_errs++;
                    $display("%s: the DUT sent more records than expected", test_name);
                end else begin
                    exp_rec = exp_q.pop_front();
                    compare("code", exp_rec[43:28], spr_code);
                    compare("x", exp_rec[27:12], spr_x);
                    compare("vsub", 16'(exp_rec[11:8]), 16'(spr_vsub));
                    compare("attr", 16'(exp_rec[7:0]), 16'(spr_attr));
                    if (got_in_line != 0 && since_valid != 3) begin
                        proto_errs++;
                        $display("%s: records %0d cycles apart instead of 3",
                                 test_name, since_valid);
                    end
                    got_in_line++;
                    records++;
                end
                since_valid = 0;
            end
            if (line_end === 1'b1) begin
                if (!line_open) begin
                    proto_errs++;
                    $display("line_end pulsed with no line in progress at %0t", $time);
                end else begin
                    if (exp_q.size() != 0) begin
                        proto_errs++;
                        $display("%s: line ended with %0d records still expected",
                                 test_name, exp_q.size());
                    end
                    if (got_in_line != 0 && since_valid != 1) begin
                        proto_errs++;
                        $display("%s: line_end came %0d cycles after the last record",
                                 test_name, since_valid);
                    end
                    line_open = 1'b0;
                    lines_done++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/obj_line_tb.sv
`timescale 1ns/1ns
`default_nettype none

module obj_line_tb
    import obj_geom_pkg::*;
    import obj_attr_pkg::*;
();

    localparam int n_lines        = 12;
    localparam int timeout_cycles = n_lines * 4000;  // table load, build and scan per line

    wire                  clk;
    wire                  rst;
    logic                 cpu_we;
    logic [frame_aw-1:0]  cpu_addr;
    logic [15:0]          cpu_data;
    logic                 start;
    logic [7:0]           vrender;
    wire                  spr_valid;
    wire                  line_end;
    wire  [15:0]          spr_code;
    wire  [15:0]          spr_x;
    wire  [ 3:0]          spr_vsub;
    wire  [ 7:0]          spr_attr;

    logic [15:0] mirror [0:entry_cnt*entry_words-1];  // copy of the frame table
    int          cycles  = 0;
    int          tb_errs = 0;

    obj_tb_clkgen u_clk (.clk(clk), .rst(rst));

    obj_line_top DUT (
        .clk(clk), .rst(rst),
        .cpu_we(cpu_we), .cpu_addr(cpu_addr), .cpu_data(cpu_data),
        .start(start), .vrender(vrender),
        .spr_valid(spr_valid), .spr_code(spr_code), .spr_x(spr_x),
        .spr_vsub(spr_vsub), .spr_attr(spr_attr), .line_end(line_end)
    );

    obj_line_checker chk (
        .clk(clk), .rst(rst),
        .spr_valid(spr_valid), .spr_code(spr_code), .spr_x(spr_x),
        .spr_vsub(spr_vsub), .spr_attr(spr_attr), .line_end(line_end)
    );

    task automatic put_entry(input int k, input logic [15:0] x, input logic [15:0] y,
                             input logic [15:0] code, input logic [15:0] attr);
        mirror[k*entry_words]     = x;
        mirror[k*entry_words + 1] = y;
        mirror[k*entry_words + 2] = code;
        mirror[k*entry_words + 3] = attr;
    endtask

    // single tile that row vr never reaches
    task automatic hidden_entry(input int k, input logic [7:0] vr);
        logic [7:0] y8;
        y8 = vr + 8'd1 + 8'($urandom % 200);
        put_entry(k, 16'($urandom), {8'd0, y8}, 16'($urandom), 16'($urandom) & 16'h00ff);
    endtask

    task automatic visible_entry(input int k, input logic [7:0] vr,
                                 input logic [3:0] tm, input logic [3:0] tn);
        logic [15:0] attr;
        logic [7:0]  off;
        off  = 8'($urandom % (tile_px * (int'(tm) + 1)));  // any row inside the sprite
        attr = 16'($urandom) & 16'h00ff;
        attr[attr_tile_m_lsb +: 4] = tm;
        attr[attr_tile_n_lsb +: 4] = tn;
        put_entry(k, 16'($urandom), {8'd0, vr - off}, 16'($urandom), attr);
    endtask

    // hidden, repeated, visible and just-missed entries
    task automatic mixed_table(input logic [7:0] vr);
        int          k;
        int          i;
        int          sel;
        logic [3:0]  tm;
        logic [7:0]  y8;
        logic [15:0] a;
        for (k = entry_cnt - 1; k >= 0; k--) begin
            sel = int'($urandom % 8);
            tm  = 4'($urandom % 4);
            if (sel < 4 || (sel < 6 && k == entry_cnt - 1)) begin
                hidden_entry(k, vr);
            end else if (sel < 6) begin
                for (i = 0; i < entry_words; i++) begin
                    mirror[k*entry_words + i] = mirror[(k+1)*entry_words + i];
                end
            end else if (sel == 6) begin
                visible_entry(k, vr, tm, 4'($urandom % 4));
            end else begin
                a = 16'($urandom) & 16'h00ff;
                a[attr_tile_m_lsb +: 4] = tm;
                a[attr_tile_n_lsb +: 4] = 4'($urandom % 4);
                y8 = ($urandom % 2 == 1) ? vr + 8'd1 : vr - 8'(tile_px * (int'(tm) + 1));
                put_entry(k, 16'($urandom), {8'd0, y8}, 16'($urandom), a);
            end
        end
    endtask

    task automatic load_table();
        int i;
        for (i = 0; i < entry_cnt * entry_words; i++) begin
            @(posedge clk);
            cpu_we   <= 1'b1;
            cpu_addr <= frame_aw'(i);
            cpu_data <= mirror[i];
        end
        @(posedge clk);
        cpu_we <= 1'b0;
    endtask

    // reference model walking the mirror from the top entry down
    task automatic expect_line(input string name, input logic [7:0] vr);
        logic [15:0] w [0:3];
        logic [7:0]  dy;
        logic [3:0]  tm, tn;
        logic        vf, hf, same;
        logic [15:0] code;
        int          k, i, c;
        int          nrec;
        nrec = 0;
        chk.begin_line(name);
        for (k = entry_cnt - 1; k >= 0 && nrec < line_slots; k--) begin
            for (i = 0; i < entry_words; i++) begin
                w[i] = mirror[k*entry_words + i];
            end
            same = 1'b0;
            if (k < entry_cnt - 1) begin
                same = 1'b1;
                for (i = 0; i < entry_words; i++) begin
                    if (w[i] != mirror[(k+1)*entry_words + i]) same = 1'b0;
                end
            end
            dy = vr - w[1][7:0];
            tm = w[3][attr_tile_m_lsb +: 4];
            tn = w[3][attr_tile_n_lsb +: 4];
            vf = w[3][attr_vflip_bit];
            hf = w[3][attr_hflip_bit];
            if (!same && int'(dy) < tile_px * (int'(tm) + 1)) begin
                for (c = 0; c <= int'(tn) && nrec < line_slots; c++) begin
                    code = w[2];
                    if (tm != 4'd0) code[7:4] = 4'(int'(dy) / tile_px);  // row index
                    if (tn != 4'd0) code[3:0] = 4'(c) ^ {4{hf}};
                    else if (tm != 4'd0) code[3:0] = w[2][3:0] ^ {4{vf}};
                    chk.push_rec(code, w[0] + 16'(c * tile_px), dy[3:0] ^ {4{vf}}, w[3][7:0]);
                    nrec++;
                end
            end
        end
    endtask

    task automatic run_line(input string name, input logic [7:0] vr);
        int target;
        expect_line(name, vr);
        target = chk.lines_done + 1;
        @(posedge clk);
        start   <= 1'b1;
        vrender <= vr;
        @(posedge clk);
        start <= 1'b0;
        while (chk.lines_done != target) @(posedge clk);  // line_end seen
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: only %0d of %0d lines finished after %0d cycles",
                     chk.lines_done, n_lines, cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        int         i;
        int         k;
        logic [7:0] vr;
        void'($urandom(7106));
        cpu_we   = 1'b0;
        cpu_addr = '0;
        cpu_data = '0;
        start    = 1'b0;
        vrender  = 8'd0;
        @(negedge rst);
        repeat (40) @(posedge clk);  // nothing may come out before a start

        for (k = 0; k < entry_cnt; k++) begin
            put_entry(k, 16'($urandom), 16'($urandom) & 16'h00ff, 16'($urandom),
                      16'($urandom) & 16'h00ff);
        end
        load_table();
        repeat (2) run_line("single_tile", 8'($urandom));

        repeat (2) begin
            vr = 8'($urandom);
            for (k = 0; k < entry_cnt; k++) begin
                if (k % 16 == 5) visible_entry(k, vr, 4'($urandom), 4'($urandom));
                else hidden_entry(k, vr);
            end
            load_table();
            run_line("multi_tile", vr);
        end

        repeat (2) begin
            vr = 8'($urandom % 24);  // low rows so tall sprites wrap past 255
            mixed_table(vr);
            load_table();
            run_line("zone_dup", vr);
        end

        vr = 8'($urandom);
        for (k = 0; k < entry_cnt; k++) begin
            visible_entry(k, vr, 4'($urandom), 4'd15);
        end
        load_table();
        run_line("full_line", vr);
        if (chk.got_in_line != line_slots) begin
            tb_errs++;
            $display("FAIL full_line: records expected %0d actual %0d",
                     line_slots, chk.got_in_line);
        end

        for (i = 0; i < 4; i++) begin
            vr = {7'($urandom), 1'(i)};  // bank alternates
            mixed_table(vr);
            load_table();
            run_line("alt_parity", vr);
        end

        vr = 8'($urandom);
        for (k = 0; k < entry_cnt; k++) begin
            hidden_entry(k, vr);
        end
        load_table();
        run_line("empty_line", vr);
        repeat (10) @(posedge clk);

        $display("errors: value %0d, protocol %0d, line count %0d (records %0d, lines %0d)",
                 chk.value_errs, chk.proto_errs, tb_errs, chk.records, chk.lines_done);
        if (chk.value_errs + chk.proto_errs + tb_errs == 0 && chk.lines_done == n_lines) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
verilog/obj_geom_pkg.sv
verilog/obj_attr_pkg.sv
verilog/obj_line_if.sv
verilog/obj_frame_table.sv
verilog/obj_line_table.sv
verilog/obj_line_scan.sv
verilog/obj_line_top.sv
dv/obj_tb_clkgen.sv
dv/obj_line_checker.sv
dv/obj_line_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the sprite line table testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module obj_line_tb \
    -f sim.f -o obj_line_sim

out=$(./obj_dir/obj_line_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1
